// File: logic/memctl_pkg.sv
/* shared constants for the load/store adapter subsystem
   access-size codes, bus widths, memory depth, latencies, refresh limits
   and the adapter state encoding */

`default_nettype none

package memctl_pkg;

   // i_ctrl: bits 1..0 size, bit 2 set means zero-extend
   localparam int CTRL_W = 3;

   localparam logic [1:0] SIZE_BYTE = 2'd0;
   localparam logic [1:0] SIZE_HALF = 2'd1;
   localparam logic [1:0] SIZE_WORD = 2'd2;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int MASK_W = 4;       // one enable per byte lane

   localparam int MEM_WORDS = 256;  // word index from addr[9:2]

   localparam int MEM_LATENCY     = 3;  // busy cycles for rd/wr
   localparam int REFRESH_LATENCY = 5;  // busy cycles for refresh

   localparam int REFRESH_INTERVAL = 200;  // due above this count
   localparam int REFRESH_LIMIT    = 405;  // late above this count

   // adapter FSM
   typedef enum logic [2:0] {
      ST_IDLE,     // waiting for core request or refresh due
      ST_RD_HI,    // read strobe given, wait for busy high
      ST_RD_LO,    // wait for busy low, capture word
      ST_RD_DONE,  // merge and extend load result
      ST_WR_HI,    // write strobe given, wait for busy high
      ST_WR_LO,    // wait for busy low
      ST_REF_HI,   // refresh strobe given
      ST_REF_LO    // refresh in progress
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/word_mem_if.sv
/* word-access bus between the load/store adapter and the word memory */

`timescale 1ns/1ps
`default_nettype none

interface word_mem_if;

   logic                            rd;       // one-cycle read strobe
   logic                            we;       // one-cycle write strobe
   logic                            refresh;  // one-cycle refresh strobe
   logic [memctl_pkg::ADDR_W-1:0]   addr;     // word aligned
   logic [memctl_pkg::DATA_W-1:0]   wdata;
   logic [memctl_pkg::MASK_W-1:0]   mask;     // active-high byte enables
   logic [memctl_pkg::DATA_W-1:0]   rdata;    // held until next read
   logic                            busy;

   // adapter side
   modport ctrl (
      output rd, we, refresh, addr, wdata, mask,
      input  rdata, busy
   );

   // memory side
   modport mem (
      input  rd, we, refresh, addr, wdata, mask,
      output rdata, busy
   );

endinterface

`default_nettype wire

// File: logic/refresh_timer.sv
/* refresh timer: saturating cycle count since last refresh,
   refresh-due level and sticky late-refresh flag */

`timescale 1ns/1ps
`default_nettype none

module refresh_timer (
   input  wire    clk,
   input  wire    rst_x,
   input  wire    i_refresh_start,
   output logic   o_refresh_due,
   output logic   o_late_refresh
);

   // wide enough to pass REFRESH_LIMIT before saturating
   logic [$clog2(memctl_pkg::REFRESH_LIMIT + 2)-1:0] r_cnt;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_cnt          <= '0;
         o_late_refresh <= 1'b0;
      end else begin
         if (i_refresh_start) begin
            r_cnt <= '0;
            if (r_cnt > memctl_pkg::REFRESH_LIMIT)
               o_late_refresh <= 1'b1;  // sticky until reset
         end else if (r_cnt != '1) begin
            r_cnt <= r_cnt + 1'b1;
         end
      end
   end

   assign o_refresh_due = (r_cnt > memctl_pkg::REFRESH_INTERVAL);

endmodule

`default_nettype wire

// File: logic/unaligned_access_ctrl.sv
/* load/store adapter: splits byte/half/word accesses at any alignment
   into one or two masked word accesses, merges and extends load data,
   and starts refresh cycles when idle */

`timescale 1ns/1ps
`default_nettype none

module unaligned_access_ctrl (
   input  wire                            clk,
   input  wire                            rst_x,
   input  wire                            i_rd_en,
   input  wire                            i_wr_en,
   input  wire [memctl_pkg::ADDR_W-1:0]   i_addr,
   input  wire [memctl_pkg::DATA_W-1:0]   i_wdata,
   input  wire [memctl_pkg::CTRL_W-1:0]   i_ctrl,
   output logic [memctl_pkg::DATA_W-1:0]  o_rdata,
   output logic                           o_busy,
   input  wire                            i_refresh_due,
   output logic                           o_refresh_start,
   word_mem_if.ctrl                       mem
);

   memctl_pkg::ctrl_state_t r_state;

   logic r_rd;
   logic r_we;
   logic r_refresh;
   logic r_second;  // working on the next word

   logic [memctl_pkg::ADDR_W-1:0]   r_addr;
   logic [memctl_pkg::CTRL_W-1:0]   r_ctrl;
   logic [memctl_pkg::DATA_W-1:0]   r_wdata;  // truncated to access size
   logic [memctl_pkg::DATA_W-1:0]   r_word0;
   logic [memctl_pkg::DATA_W-1:0]   r_word1;

   logic [1:0]                      w_off;
   logic [memctl_pkg::MASK_W-1:0]   w_base_mask;
   logic [2*memctl_pkg::MASK_W-1:0] w_mask2;
   logic [2*memctl_pkg::DATA_W-1:0] w_data2;
   logic [2*memctl_pkg::DATA_W-1:0] w_merged;
   logic                            w_cross;
   logic                            w_accept;

   // sign or zero extension of the shifted load word
   function automatic logic [memctl_pkg::DATA_W-1:0] extend_load(
      input logic [memctl_pkg::DATA_W-1:0] v,
      input logic [memctl_pkg::CTRL_W-1:0] ctrl
   );
      case (ctrl[1:0])
         memctl_pkg::SIZE_BYTE:
            return ctrl[2] ? memctl_pkg::DATA_W'(v[7:0])
                           : memctl_pkg::DATA_W'(signed'(v[7:0]));
         memctl_pkg::SIZE_HALF:
            return ctrl[2] ? memctl_pkg::DATA_W'(v[15:0])
                           : memctl_pkg::DATA_W'(signed'(v[15:0]));
         default:
            return v;
      endcase
   endfunction

   assign w_off    = r_addr[1:0];
   assign w_accept = (r_state == memctl_pkg::ST_IDLE) && (i_rd_en || i_wr_en);

   always_comb begin
      case (r_ctrl[1:0])
         memctl_pkg::SIZE_BYTE: w_base_mask = 4'b0001;
         memctl_pkg::SIZE_HALF: w_base_mask = 4'b0011;
         default:               w_base_mask = 4'b1111;
      endcase
   end

   // two-word window, lower half is the first word
   assign w_mask2  = {{memctl_pkg::MASK_W{1'b0}}, w_base_mask} << w_off;
   assign w_data2  = {{memctl_pkg::DATA_W{1'b0}}, r_wdata} << {w_off, 3'b000};
   assign w_merged = {r_word1, r_word0} >> {w_off, 3'b000};
   assign w_cross  = |w_mask2[2*memctl_pkg::MASK_W-1:memctl_pkg::MASK_W];

   assign mem.rd      = r_rd;
   assign mem.we      = r_we;
   assign mem.refresh = r_refresh;
   assign mem.addr    = {r_addr[memctl_pkg::ADDR_W-1:2] + (memctl_pkg::ADDR_W-2)'(r_second),
                         2'b00};
   assign mem.wdata   = r_second ? w_data2[2*memctl_pkg::DATA_W-1:memctl_pkg::DATA_W]
                                 : w_data2[memctl_pkg::DATA_W-1:0];
   assign mem.mask    = r_second ? w_mask2[2*memctl_pkg::MASK_W-1:memctl_pkg::MASK_W]
                                 : w_mask2[memctl_pkg::MASK_W-1:0];

   assign o_busy          = (r_state != memctl_pkg::ST_IDLE);
   assign o_refresh_start = r_refresh;  // also clears the timer

   // request payload and returned words
   always_ff @(posedge clk) begin
      if (w_accept) begin
         r_addr <= i_addr;
         r_ctrl <= i_ctrl;
         case (i_ctrl[1:0])
            memctl_pkg::SIZE_BYTE: r_wdata <= memctl_pkg::DATA_W'(i_wdata[7:0]);
            memctl_pkg::SIZE_HALF: r_wdata <= memctl_pkg::DATA_W'(i_wdata[15:0]);
            default:               r_wdata <= i_wdata;
         endcase
      end
      if (r_state == memctl_pkg::ST_RD_LO && !mem.busy) begin
         if (r_second)
            r_word1 <= mem.rdata;
         else
            r_word0 <= mem.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_state   <= memctl_pkg::ST_IDLE;
         r_rd      <= 1'b0;
         r_we      <= 1'b0;
         r_refresh <= 1'b0;
         r_second  <= 1'b0;
         o_rdata   <= '0;
      end else begin
         r_rd      <= 1'b0;  // strobes last one cycle
         r_we      <= 1'b0;
         r_refresh <= 1'b0;
         case (r_state)
            memctl_pkg::ST_IDLE: begin
               r_second <= 1'b0;
               if (i_rd_en) begin  // read wins over write
                  r_rd    <= 1'b1;
                  r_state <= memctl_pkg::ST_RD_HI;
               end else if (i_wr_en) begin
                  r_we    <= 1'b1;
                  r_state <= memctl_pkg::ST_WR_HI;
               end else if (i_refresh_due) begin
                  r_refresh <= 1'b1;
                  r_state   <= memctl_pkg::ST_REF_HI;
               end
            end
            memctl_pkg::ST_RD_HI:
               if (mem.busy) r_state <= memctl_pkg::ST_RD_LO;
            memctl_pkg::ST_RD_LO:
               if (!mem.busy) begin
                  if (!r_second && w_cross) begin  // fetch next word too
                     r_second <= 1'b1;
                     r_rd     <= 1'b1;
                     r_state  <= memctl_pkg::ST_RD_HI;
                  end else begin
                     r_state <= memctl_pkg::ST_RD_DONE;
                  end
               end
            memctl_pkg::ST_RD_DONE: begin
               o_rdata <= extend_load(w_merged[memctl_pkg::DATA_W-1:0], r_ctrl);
               r_state <= memctl_pkg::ST_IDLE;
            end
            memctl_pkg::ST_WR_HI:
               if (mem.busy) r_state <= memctl_pkg::ST_WR_LO;
            memctl_pkg::ST_WR_LO:
               if (!mem.busy) begin
                  if (!r_second && w_cross) begin  // remaining bytes
                     r_second <= 1'b1;
                     r_we     <= 1'b1;
                     r_state  <= memctl_pkg::ST_WR_HI;
                  end else begin
                     r_state <= memctl_pkg::ST_IDLE;
                  end
               end
            memctl_pkg::ST_REF_HI:
               if (mem.busy) r_state <= memctl_pkg::ST_REF_LO;
            memctl_pkg::ST_REF_LO:
               if (!mem.busy) r_state <= memctl_pkg::ST_IDLE;
            default:
               r_state <= memctl_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/word_mem_model.sv
/* behavioral word memory standing in for the SDRAM controller
   byte-masked writes, registered reads, fixed busy period per strobe */

`timescale 1ns/1ps
`default_nettype none

module word_mem_model (
   input  wire       clk,
   input  wire       rst_x,
   word_mem_if.mem   bus
);

   // cleared at start of simulation only
   logic [memctl_pkg::DATA_W-1:0] r_mem [memctl_pkg::MEM_WORDS] = '{default: '0};

   logic [$clog2(memctl_pkg::REFRESH_LATENCY + 1)-1:0] r_busy_cnt;
   logic [$clog2(memctl_pkg::MEM_WORDS)-1:0]           w_idx;
   logic                                               w_ready;

   assign w_idx    = bus.addr[$clog2(memctl_pkg::MEM_WORDS)+1:2];  // upper bits ignored
   assign w_ready  = (r_busy_cnt == '0);
   assign bus.busy = !w_ready;

   // busy down-counter, loaded when a strobe is taken
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_busy_cnt <= '0;
      end else if (w_ready) begin
         if (bus.refresh)
            r_busy_cnt <= ($bits(r_busy_cnt))'(memctl_pkg::REFRESH_LATENCY);
         else if (bus.rd || bus.we)
            r_busy_cnt <= ($bits(r_busy_cnt))'(memctl_pkg::MEM_LATENCY);
      end else begin
         r_busy_cnt <= r_busy_cnt - 1'b1;
      end
   end

   // array access happens as the strobe is taken
   always_ff @(posedge clk) begin
      if (w_ready && bus.we) begin
         for (int b = 0; b < memctl_pkg::MASK_W; b++) begin
            if (bus.mask[b])
               r_mem[w_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
         end
      end
      if (w_ready && bus.rd)
         bus.rdata <= r_mem[w_idx];  // held until next read
   end

endmodule

`default_nettype wire

// File: logic/mem_subsys_top.sv
/* memory subsystem top: adapter, refresh timer and word memory
   with plain core-side ports */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
   input  wire                            clk,
   input  wire                            rst_x,
   input  wire                            i_rd_en,
   input  wire                            i_wr_en,
   input  wire [memctl_pkg::ADDR_W-1:0]   i_addr,
   input  wire [memctl_pkg::DATA_W-1:0]   i_wdata,
   input  wire [memctl_pkg::CTRL_W-1:0]   i_ctrl,
   output wire [memctl_pkg::DATA_W-1:0]   o_rdata,
   output wire                            o_busy,
   output wire                            o_late_refresh
);

   wire w_refresh_due;
   wire w_refresh_start;

   word_mem_if u_bus ();

   unaligned_access_ctrl u_ctrl (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_rd_en         (i_rd_en),
      .i_wr_en         (i_wr_en),
      .i_addr          (i_addr),
      .i_wdata         (i_wdata),
      .i_ctrl          (i_ctrl),
      .o_rdata         (o_rdata),
      .o_busy          (o_busy),
      .i_refresh_due   (w_refresh_due),
      .o_refresh_start (w_refresh_start),
      .mem             (u_bus.ctrl)
   );

   refresh_timer u_timer (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_refresh_start (w_refresh_start),
      .o_refresh_due   (w_refresh_due),
      .o_late_refresh  (o_late_refresh)
   );

   word_mem_model u_mem (
      .clk   (clk),
      .rst_x (rst_x),
      .bus   (u_bus.mem)
   );

endmodule

`default_nettype wire

// File: testbench/tb_mem_subsys.sv
/* testbench for the memory subsystem: LFSR-driven load/store traffic,
   byte-array reference model, result checks and a watchdog */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

   localparam int N_RAND = 600;  // random requests after the fill phase
   localparam int N_REQ  = 2 * memctl_pkg::MEM_WORDS + N_RAND;

   logic                            clk = 1'b0;
   logic                            rst_x;
   logic                            i_rd_en;
   logic                            i_wr_en;
   logic [memctl_pkg::ADDR_W-1:0]   i_addr;
   logic [memctl_pkg::DATA_W-1:0]   i_wdata;
   logic [memctl_pkg::CTRL_W-1:0]   i_ctrl;
   wire  [memctl_pkg::DATA_W-1:0]   o_rdata;
   wire                             o_busy;
   wire                             o_late_refresh;

   logic [31:0] lfsr = 32'h39bfdbea;
   logic [7:0]  ref_mem [4*memctl_pkg::MEM_WORDS] = '{default: 8'h00};  // byte model
   int          refresh_cnt = 0;

   mem_subsys_top uut (
      .clk            (clk),
      .rst_x          (rst_x),
      .i_rd_en        (i_rd_en),
      .i_wr_en        (i_wr_en),
      .i_addr         (i_addr),
      .i_wdata        (i_wdata),
      .i_ctrl         (i_ctrl),
      .o_rdata        (o_rdata),
      .o_busy         (o_busy),
      .o_late_refresh (o_late_refresh)
   );

   always #50 clk = ~clk;

   // count refresh pulses inside the DUT
   always @(posedge clk) begin
      if (rst_x === 1'b1 && uut.w_refresh_start)
         refresh_cnt <= refresh_cnt + 1;
   end

   // one Galois step, taps 32 22 2 1
   function automatic logic [31:0] step_lfsr(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};  // one step per bit taken
         lfsr = step_lfsr(lfsr);
      end
      return v;
   endfunction

   function automatic int size_bytes(input logic [1:0] sz);
      case (sz)
         memctl_pkg::SIZE_BYTE: return 1;
         memctl_pkg::SIZE_HALF: return 2;
         default:               return 4;
      endcase
   endfunction

   // little-endian store of the low bytes
   function automatic void model_store(input int addr, input logic [2:0] ctrl,
                                       input logic [31:0] data);
      for (int b = 0; b < size_bytes(ctrl[1:0]); b++)
         ref_mem[addr + b] = data[8*b +: 8];
   endfunction

   function automatic logic [31:0] expected_load(input int addr, input logic [2:0] ctrl);
      logic [31:0] v;
      int          n;
      v = '0;
      n = size_bytes(ctrl[1:0]);
      for (int b = 0; b < 4; b++) begin
         if (b < n)
            v[8*b +: 8] = ref_mem[addr + b];
         else if (!ctrl[2] && v[8*n-1])
            v[8*b +: 8] = 8'hff;  // sign fill
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (got === exp) else begin
         $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
         $display("Done: errors found");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // request held until a cycle with o_busy low, then wait for completion
   task automatic issue_request(input logic is_rd, input logic [2:0] ctrl,
                                input int addr, input logic [31:0] data);
      @(posedge clk);
      i_rd_en <= is_rd;
      i_wr_en <= !is_rd;
      i_addr  <= 32'(addr);
      i_wdata <= data;
      i_ctrl  <= ctrl;
      do
         @(negedge clk);
      while (o_busy);  // a refresh may still be running
      @(posedge clk);  // taken on this edge
      i_rd_en <= 1'b0;
      i_wr_en <= 1'b0;
      if (!is_rd)
         model_store(addr, ctrl, data);
      do
         @(negedge clk);
      while (o_busy);
      if (is_rd)
         check_value("o_rdata", expected_load(addr, ctrl), o_rdata);
      check_value("o_late_refresh", 32'd0, 32'(o_late_refresh));
   endtask

   initial begin
      int          gap;
      int          addr;
      logic [2:0]  ctrl;
      logic        is_rd;
      rst_x   <= 1'b0;
      i_rd_en <= 1'b0;
      i_wr_en <= 1'b0;
      i_addr  <= '0;
      i_wdata <= '0;
      i_ctrl  <= '0;
      repeat (5) @(posedge clk);
      rst_x <= 1'b1;
      @(negedge clk);
      check_value("o_busy", 32'd0, 32'(o_busy));
      check_value("o_late_refresh", 32'd0, 32'(o_late_refresh));
      check_value("o_rdata", 32'd0, o_rdata);

      // aligned word fill of the whole memory, then read back
      for (int w = 0; w < memctl_pkg::MEM_WORDS; w++)
         issue_request(1'b0, {1'b0, memctl_pkg::SIZE_WORD}, 4*w, rand_bits(32));
      for (int w = 0; w < memctl_pkg::MEM_WORDS; w++)
         issue_request(1'b1, {1'b0, memctl_pkg::SIZE_WORD}, 4*w, 32'd0);

      // mixed sizes, signs and offsets with idle gaps
      for (int i = 0; i < N_RAND; i++) begin
         gap = int'(rand_bits(9) % 301);
         repeat (gap) @(posedge clk);
         is_rd = (rand_bits(1) != 0);
         ctrl  = 3'(rand_bits(3));
         if (ctrl[1:0] == 2'd3)
            ctrl[1:0] = memctl_pkg::SIZE_WORD;
         addr = int'(rand_bits(10) % 1020);  // never past the last byte
         issue_request(is_rd, ctrl, addr, rand_bits(32));
      end

      assert (refresh_cnt > 0) begin
         $display("%0d requests, %0d refresh cycles", N_REQ, refresh_cnt);
         $display("Done: no errors");
         $finish;
      end else begin
         $display("no refresh cycle was seen during the idle gaps");
         $display("Done: errors found");
         $fatal(1, "refresh never ran");
      end
   end

   // watchdog, about 1000 cycles per request
   initial begin
      repeat (N_REQ * 1000) @(posedge clk);
      $display("TIMEOUT: o_busy did not fall, a request hung after %0d cycles", N_REQ * 1000);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: tb.f
logic/memctl_pkg.sv
logic/word_mem_if.sv
logic/refresh_timer.sv
logic/unaligned_access_ctrl.sv
logic/word_mem_model.sv
logic/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

SIM := obj_dir/Vtb_mem_subsys

all: run

$(SIM): tb.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv)
	verilator --binary -j 0 -Wno-fatal --top-module tb_mem_subsys -f tb.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
	   echo "simulation failed, see sim.log"; exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
